// File: bpu_pkg.sv
// branch kinds, field widths, queue depth and counter constants for the update path
package bpu_pkg;

    // branch kind encoding as resolved in execute
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } br_kind_e;

    localparam int PC_W = 30;   // word address
    localparam int PDCH_W = 8;  // fetch-time table index
    localparam int PHT_DEPTH = 1 << PDCH_W;

    // update queue
    localparam int BUF_DEPTH = 6;
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

    // two-bit saturating counters
    localparam logic [1:0] CTR_INIT = 2'b01;  // weakly not taken
    localparam logic [1:0] CTR_MAX = 2'b11;
    localparam logic [1:0] CTR_MIN = 2'b00;

endpackage

// File: br_lane_if.sv
// interface for one resolved lane record, resolver to update queue
`timescale 1ns/1ps

interface br_lane_if import bpu_pkg::*; ();

    logic              valid;
    br_kind_e          kind;
    logic              taken;
    logic [PC_W-1:0]   npc;
    logic [PC_W-1:0]   pc;
    logic [PDCH_W-1:0] pdch;
    logic              pack_size;  // 0: one slot, 1: two slots
    logic              flush_pre;  // prediction was wrong

    modport src (
        output valid, kind, taken, npc, pc, pdch, pack_size, flush_pre
    );

    modport dst (
        input valid, kind, taken, npc, pc, pdch, pack_size, flush_pre
    );

endinterface

// File: bpu_upd_if.sv
// interface for the merged predictor update, update queue to counter table
`timescale 1ns/1ps

interface bpu_upd_if import bpu_pkg::*; ();

    logic              update_en;  // one-cycle strobe
    br_kind_e          kind;
    logic              taken;
    logic [PDCH_W-1:0] pdch;

    modport src (
        output update_en, kind, taken, pdch
    );

    modport dst (
        input update_en, kind, taken, pdch
    );

endinterface

// File: br_resolve.sv
// per-lane branch resolver, registers the outcome and flags a misprediction
`timescale 1ns/1ps

module br_resolve import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              valid,
    input  logic [PC_W-1:0]   pc,
    input  br_kind_e          kind,
    input  logic              taken,       // actual direction
    input  logic [PC_W-1:0]   npc,         // actual target
    input  logic              pred_taken,
    input  logic [PC_W-1:0]   pred_npc,
    input  logic [PDCH_W-1:0] pdch,
    input  logic              pack_size,
    br_lane_if.src            lane
);

    logic dir_miss;
    logic tgt_miss;
    logic mispredict;

    assign dir_miss = pred_taken != taken;
    // target only matters when the branch really went
    assign tgt_miss = taken && (pred_npc != npc);
    assign mispredict = dir_miss || tgt_miss;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane.valid <= 1'b0;
        end else begin
            lane.valid <= valid;
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (valid) begin
            lane.kind      <= kind;
            lane.taken     <= taken;
            lane.npc       <= npc;
            lane.pc        <= pc;
            lane.pdch      <= pdch;
            lane.pack_size <= pack_size;
            lane.flush_pre <= mispredict;
        end
    end

endmodule

// File: ex_buffer.sv
// update queue with packet pop, merge of two-slot packets and registered update outputs
`timescale 1ns/1ps

module ex_buffer import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            stall,
    input  logic [1:0]      flag,     // 10: lane 0, 01: lane 1, 11: both
    br_lane_if.dst          lane0,
    br_lane_if.dst          lane1,
    bpu_upd_if.src          upd,
    output logic [PC_W-1:0] out_npc,
    output logic [PC_W-1:0] out_pc,
    output logic [PC_W-1:0] ret_pc
);

    typedef struct packed {
        br_kind_e          kind;
        logic              taken;
        logic [PC_W-1:0]   npc;
        logic [PC_W-1:0]   pc;
        logic [PDCH_W-1:0] pdch;
        logic              pack_size;
        logic              flush_pre;
    } entry_t;

    entry_t buf_q [BUF_DEPTH];

    logic [BUF_PTR_W-1:0] head;
    logic [BUF_PTR_W-1:0] count;
    logic [BUF_PTR_W-1:0] tail;
    logic [1:0]           pkt_flag;   // flag and stall lined up with the lane records
    logic                 pkt_stall;
    logic [1:0]           n_wr;
    logic [1:0]           n_pop;

    entry_t rec0;
    entry_t rec1;
    entry_t first_rec;
    entry_t head_e;
    entry_t next_e;
    logic   head_single;
    logic   is_pair;

    br_kind_e        mrg_kind;
    logic            mrg_taken;
    logic [PC_W-1:0] mrg_npc;
    logic [PC_W-1:0] mrg_ret;

    function automatic logic [BUF_PTR_W-1:0] ptr_add(input logic [BUF_PTR_W-1:0] p,
                                                    input logic [BUF_PTR_W-1:0] n);
        logic [BUF_PTR_W:0] s;
        s = p + n;
        if (s >= (BUF_PTR_W+1)'(BUF_DEPTH)) s = s - (BUF_PTR_W+1)'(BUF_DEPTH);
        return s[BUF_PTR_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pkt_flag  <= 2'b00;
            pkt_stall <= 1'b0;
        end else begin
            pkt_flag  <= flag;
            pkt_stall <= stall;
        end
    end

    assign rec0 = '{lane0.kind, lane0.taken, lane0.npc, lane0.pc, lane0.pdch,
                    lane0.pack_size, lane0.flush_pre};
    // lane 1 only opens a packet when it comes alone
    assign rec1 = '{lane1.kind, lane1.taken, lane1.npc, lane1.pc, lane1.pdch,
                    lane1.pack_size & ~lane0.valid, lane1.flush_pre};
    assign first_rec = lane0.valid ? rec0 : rec1;

    always_comb begin
        n_wr = 2'd0;
        if (!pkt_stall) begin
            if (pkt_flag == 2'b11)      n_wr = 2'd2;
            else if (pkt_flag != 2'b00) n_wr = 2'd1;
        end
    end

    assign tail = ptr_add(head, count);

    // new records go behind the youngest queued one
    always_ff @(posedge clk) begin
        if (n_wr != 2'd0) buf_q[tail] <= first_rec;
        if (n_wr == 2'd2) buf_q[ptr_add(tail, 1)] <= rec1;
    end

    assign head_e = buf_q[head];
    assign next_e = buf_q[ptr_add(head, 1)];
    assign head_single = !head_e.pack_size || head_e.flush_pre;  // younger slot dropped

    always_comb begin
        n_pop = 2'd0;
        if (count != '0) begin
            if (head_single)    n_pop = 2'd1;
            else if (count > 1) n_pop = 2'd2;  // else pair still incomplete
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= '0;
            count <= '0;
        end else begin
            head  <= ptr_add(head, BUF_PTR_W'(n_pop));
            count <= count + BUF_PTR_W'(n_wr) - BUF_PTR_W'(n_pop);
        end
    end

    assign is_pair = n_pop == 2'd2;

    always_comb begin
        mrg_kind  = head_e.kind;
        mrg_taken = head_e.taken;
        mrg_npc   = head_e.npc;
        mrg_ret   = head_e.pc + 1'b1;
        if (is_pair) begin
            mrg_taken = head_e.taken || next_e.taken;
            if (head_e.kind == DIRECT_JUMP || next_e.kind == DIRECT_JUMP)
                mrg_kind = DIRECT_JUMP;
            else if (head_e.kind == CALL || next_e.kind == CALL)
                mrg_kind = CALL;
            else if (head_e.kind == RET || next_e.kind == RET)
                mrg_kind = RET;
            else if (head_e.kind == INDIRECT_JUMP || next_e.kind == INDIRECT_JUMP)
                mrg_kind = INDIRECT_JUMP;
            else
                mrg_kind = NOT_JUMP;
            mrg_npc = head_e.taken ? head_e.npc : next_e.npc;
            if (next_e.kind == CALL && head_e.kind != CALL)
                mrg_ret = next_e.pc + 1'b1;  // call sits in the younger slot
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            upd.update_en <= 1'b0;
        end else begin
            upd.update_en <= n_pop != 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (n_pop != 2'd0) begin
            upd.kind  <= mrg_kind;
            upd.taken <= mrg_taken;
            upd.pdch  <= head_e.pdch;
            out_npc   <= mrg_npc;
            out_pc    <= head_e.pc;
            ret_pc    <= mrg_ret;
        end
    end

endmodule

// File: pht_update.sv
// two-bit saturating counter table trained by merged updates, with a read port
`timescale 1ns/1ps

module pht_update import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    bpu_upd_if.dst            upd,
    input  logic [PDCH_W-1:0] query_idx,
    output logic [1:0]        query_ctr
);

    logic [1:0] ctr_q [PHT_DEPTH];
    logic [1:0] cur_ctr;
    logic [1:0] nxt_ctr;
    logic       train;

    assign cur_ctr = ctr_q[upd.pdch];
    // non-branches leave the table alone
    assign train = upd.update_en && (upd.kind != NOT_JUMP);

    always_comb begin
        nxt_ctr = cur_ctr;
        if (upd.taken) begin
            if (cur_ctr != CTR_MAX) nxt_ctr = cur_ctr + 2'd1;
        end else begin
            if (cur_ctr != CTR_MIN) nxt_ctr = cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (train) begin
            ctr_q[upd.pdch] <= nxt_ctr;
        end
    end

    assign query_ctr = ctr_q[query_idx];

endmodule

// File: bpu_update_top.sv
// top of the branch update path: two resolvers, update queue and counter table
`timescale 1ns/1ps

module bpu_update_top import bpu_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic [1:0]        flag,
    input  logic              stall,
    input  logic [PC_W-1:0]   pc_0,
    input  br_kind_e          kind_0,
    input  logic              taken_0,
    input  logic [PC_W-1:0]   npc_0,
    input  logic              pred_taken_0,
    input  logic [PC_W-1:0]   pred_npc_0,
    input  logic [PDCH_W-1:0] pdch_0,
    input  logic              pack_size_0,
    input  logic [PC_W-1:0]   pc_1,
    input  br_kind_e          kind_1,
    input  logic              taken_1,
    input  logic [PC_W-1:0]   npc_1,
    input  logic              pred_taken_1,
    input  logic [PC_W-1:0]   pred_npc_1,
    input  logic [PDCH_W-1:0] pdch_1,
    input  logic              pack_size_1,
    input  logic [PDCH_W-1:0] query_idx,
    output logic              update_en,
    output br_kind_e          upd_kind,
    output logic              upd_taken,
    output logic [PC_W-1:0]   upd_npc,
    output logic [PC_W-1:0]   upd_pc,
    output logic [PC_W-1:0]   ret_pc,
    output logic [1:0]        query_ctr
);

    br_lane_if lane0 ();
    br_lane_if lane1 ();
    bpu_upd_if upd ();

    br_resolve u_res0 (
        .clk(clk), .rstn(rstn), .valid(flag[1]),  // lane 0 is the older slot
        .pc(pc_0), .kind(kind_0), .taken(taken_0), .npc(npc_0),
        .pred_taken(pred_taken_0), .pred_npc(pred_npc_0), .pdch(pdch_0),
        .pack_size(pack_size_0), .lane(lane0.src)
    );

    br_resolve u_res1 (
        .clk(clk), .rstn(rstn), .valid(flag[0]),
        .pc(pc_1), .kind(kind_1), .taken(taken_1), .npc(npc_1),
        .pred_taken(pred_taken_1), .pred_npc(pred_npc_1), .pdch(pdch_1),
        .pack_size(pack_size_1), .lane(lane1.src)
    );

    ex_buffer u_buf (
        .clk(clk), .rstn(rstn), .stall(stall), .flag(flag),
        .lane0(lane0.dst), .lane1(lane1.dst), .upd(upd.src),
        .out_npc(upd_npc), .out_pc(upd_pc), .ret_pc(ret_pc)
    );

    pht_update u_pht (
        .clk(clk), .rstn(rstn), .upd(upd.dst),
        .query_idx(query_idx), .query_ctr(query_ctr)
    );

    assign update_en = upd.update_en;
    assign upd_kind  = upd.kind;
    assign upd_taken = upd.taken;

endmodule

// File: tb_clk_gen.sv
// testbench clock and synchronous reset source
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD     = 40.0,
    parameter int  RST_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;  // released on a rising edge
    end

endmodule

// File: tb_bpu_update.sv
// testbench for the branch update path, driven and checked from the golden file
`timescale 1ns/1ps

module tb_bpu_update import bpu_pkg::*; ();

    localparam int MAX_TESTS = 64;

    typedef struct packed {
        logic [7:0]      test;
        logic [2:0]      kind;
        logic            taken;
        logic [PC_W-1:0] npc;
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] ret;
    } exp_t;

    logic              clk;
    logic              rstn;
    logic [1:0]        flag;
    logic              stall;
    logic [PC_W-1:0]   pc_0, npc_0, pred_npc_0, pc_1, npc_1, pred_npc_1;
    br_kind_e          kind_0, kind_1;
    logic              taken_0, pred_taken_0, pack_size_0;
    logic              taken_1, pred_taken_1, pack_size_1;
    logic [PDCH_W-1:0] pdch_0, pdch_1, query_idx;
    logic              update_en;
    br_kind_e          upd_kind;
    logic              upd_taken;
    logic [PC_W-1:0]   upd_npc, upd_pc, ret_pc;
    logic [1:0]        query_ctr;

    string       lines[$];
    logic [31:0] v [30];  // fields of the packet line being driven
    exp_t        exp_q[$];
    string       test_nm [MAX_TESTS];
    int          test_left [MAX_TESTS];
    int          test_err [MAX_TESTS];
    bit          test_done [MAX_TESTS];
    int          tcnt = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;

    tb_clk_gen #(.PERIOD(40.0), .RST_CYCLES(16)) u_clk (.clk(clk), .rstn(rstn));

    bpu_update_top u_dut (.*);

    task automatic apply_packet();
        flag         <= v[0][1:0];
        stall        <= v[1][0];
        pc_0         <= v[3][PC_W-1:0];
        kind_0       <= br_kind_e'(v[4][2:0]);
        taken_0      <= v[5][0];
        npc_0        <= v[6][PC_W-1:0];
        pred_taken_0 <= v[7][0];
        pred_npc_0   <= v[8][PC_W-1:0];
        pdch_0       <= v[9][PDCH_W-1:0];
        pack_size_0  <= v[10][0];
        pc_1         <= v[11][PC_W-1:0];
        kind_1       <= br_kind_e'(v[12][2:0]);
        taken_1      <= v[13][0];
        npc_1        <= v[14][PC_W-1:0];
        pred_taken_1 <= v[15][0];
        pred_npc_1   <= v[16][PC_W-1:0];
        pdch_1       <= v[17][PDCH_W-1:0];
        pack_size_1  <= v[18][0];
    endtask

    task automatic push_expected(input int t);
        exp_t e;
        for (int k = 0; k < int'(v[19]); k++) begin
            e.test  = t[7:0];
            e.kind  = v[20+5*k][2:0];
            e.taken = v[21+5*k][0];
            e.npc   = v[22+5*k][PC_W-1:0];
            e.pc    = v[23+5*k][PC_W-1:0];
            e.ret   = v[24+5*k][PC_W-1:0];
            exp_q.push_back(e);
        end
    endtask

    task automatic report_test(input int t);
        test_done[t] = 1'b1;
        if (test_err[t] == 0) begin
            $display("[PASS] %s", test_nm[t]);
            n_pass++;
        end else begin
            $display("test %s finished with %0d mismatches", test_nm[t], test_err[t]);
            n_fail++;
        end
    endtask

    task automatic compare_field(input int t, input string f, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s %s expected %0h actual %0h", test_nm[t], f, exp_v, act_v);
            test_err[t]++;
            errors++;
        end
    endtask

    // update fields settle long before the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (rstn && update_en === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("update_en pulsed with no update expected at cycle %0d", cycles);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_field(e.test, "kind", e.kind, upd_kind);
                compare_field(e.test, "taken", e.taken, upd_taken);
                compare_field(e.test, "npc", e.npc, upd_npc);
                compare_field(e.test, "pc", e.pc, upd_pc);
                compare_field(e.test, "ret_pc", e.ret, ret_pc);
                test_left[e.test]--;
                if (test_left[e.test] == 0) report_test(e.test);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d updates never arrived", cycles, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        string line;
        string tag;
        string nm;
        int fd;
        int n;
        logic [31:0] qi;
        logic [31:0] qc;
        foreach (v[k]) v[k] = '0;
        apply_packet();  // all lane inputs idle
        query_idx = '0;
        void'($urandom(71696));
        fd = $fopen("bpu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open bpu_golden.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") lines.push_back(line);
            end
            $fclose(fd);
        end
        cycle_limit = 40 * lines.size() + 16;
        wait (rstn === 1'b1);

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", tag));
            if (tag == "P") begin
                n = $sscanf(lines[i],
                            "%s%s%b%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                            tag, nm, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                            v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                            v[18], v[19], v[20], v[21], v[22], v[23], v[24], v[25], v[26],
                            v[27], v[28], v[29]);
                if (n != 32) begin
                    $display("packet line %0d of the golden file is malformed", i);
                    errors++;
                end else begin
                    if (v[2] == 0) begin
                        repeat ($urandom % 3) begin
                            @(posedge clk);
                            flag  <= 2'b00;
                            stall <= $urandom % 2;  // idle or stall cycle
                        end
                    end
                    @(posedge clk);
                    apply_packet();
                    test_nm[tcnt] = nm;
                    test_left[tcnt] = v[19];
                    push_expected(tcnt);
                    tcnt++;
                end
            end
        end
        @(posedge clk);
        flag  <= 2'b00;
        stall <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // room for a stray update to show up
        for (int t = 0; t < tcnt; t++) begin
            if (!test_done[t]) report_test(t);
        end

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", tag));
            if (tag == "Q") begin
                n = $sscanf(lines[i], "%s %s %h %h", tag, nm, qi, qc);
                test_nm[tcnt] = nm;
                if (n != 4) begin
                    $display("query line %0d of the golden file is malformed", i);
                    test_err[tcnt]++;
                    errors++;
                end else begin
                    @(posedge clk);
                    query_idx <= qi[PDCH_W-1:0];
                    @(negedge clk);
                    if (query_ctr !== qc[1:0]) begin
                        $display("[FAIL] %s counter expected %0d actual %0d", nm, qc[1:0],
                                 query_ctr);
                        test_err[tcnt]++;
                        errors++;
                    end
                end
                report_test(tcnt);
                tcnt++;
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d", tcnt, n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: bpu_golden.txt
# P name flag(bin) stall burst, lane0 then lane1: pc kind taken npc pred_taken pred_npc pdch pack
# then n_exp, two updates: kind taken npc pc ret_pc.  Q name idx ctr.  values in hex
P single_l0_br 10 0 0 100 1 1 200 1 200 10 0 0 0 0 0 0 0 0 0 1 1 1 200 100 101 0 0 0 0 0
P single_l1_nt 01 0 0 0 0 0 0 0 0 0 0 120 1 0 121 0 0 11 0 1 1 0 121 120 121 0 0 0 0 0
P single_nojump 10 0 0 130 0 0 131 0 0 12 0 0 0 0 0 0 0 0 0 1 0 0 131 130 131 0 0 0 0 0
P pair_call_young 11 0 0 140 0 0 141 0 0 13 1 141 6 1 300 1 300 13 1 1 6 1 300 140 142 0 0 0 0 0
P pair_ret_old 11 0 0 150 4 1 400 1 400 14 1 151 5 1 500 1 500 14 1 1 4 1 400 150 151 0 0 0 0 0
P pair_direct_prio 11 0 0 160 5 0 161 0 0 15 1 161 1 0 162 0 0 15 1 1 1 0 162 160 161 0 0 0 0 0
P mispredict_dir 11 0 0 170 1 1 600 0 0 16 1 171 6 1 700 1 700 17 1 2 1 1 600 170 171 6 1 700 171 172
P mispredict_tgt 11 0 0 180 5 1 800 1 810 16 1 181 0 0 182 0 0 18 1 2 5 1 800 180 181 0 0 182 181 182
P stall_pair 11 1 0 190 1 1 900 1 900 19 1 191 1 1 901 1 901 19 1 0 0 0 0 0 0 0 0 0 0 0
P burst_a 11 0 0 1a0 4 0 1a1 0 0 20 1 1a1 6 1 a00 1 a00 20 1 1 6 1 a00 1a0 1a2 0 0 0 0 0
P burst_b 11 0 1 1b0 6 1 b00 1 b00 20 1 1b1 6 1 b10 1 b10 20 1 1 6 1 b00 1b0 1b1 0 0 0 0 0
P burst_c 11 0 1 1c0 1 1 c00 1 c00 20 1 1c1 0 0 1c2 0 0 21 1 1 1 1 c00 1c0 1c1 0 0 0 0 0
P sat_low 10 0 0 1d0 7 0 1d1 0 0 11 0 0 0 0 0 0 0 0 0 1 7 0 1d1 1d0 1d1 0 0 0 0 0
Q ctr_10 10 2
Q ctr_11 11 0
Q ctr_12 12 1
Q ctr_13 13 2
Q ctr_14 14 2
Q ctr_15 15 0
Q ctr_16 16 3
Q ctr_17 17 2
Q ctr_18 18 1
Q ctr_19 19 1
Q ctr_20 20 3
Q ctr_21 21 1

// File: all.f
bpu_pkg.sv
br_lane_if.sv
bpu_upd_if.sv
br_resolve.sv
ex_buffer.sv
pht_update.sv
bpu_update_top.sv
tb_clk_gen.sv
tb_bpu_update.sv
